/* hdl/chan_pkg.sv */
// Shared types and constants for the channel buffer; referenced as chan_pkg::name.
package chan_pkg;

        // ============================================================
        // Request sizes
        // ============================================================

        // Burst length carried by alloc and drain strobes
        // Counted in beats, up to 255 per request
        typedef logic [7:0] size_t;

        // ============================================================
        // Skid bridge
        // ============================================================

        // Entries in the bridge skid
        // Power of two so the skid pointers wrap on their own
        // Also bounds the reported bridge occupancy
        localparam int SKID_DEPTH = 4;

        // Read-return tracking in the bridge
        // BR_IDLE means no buffer read in flight
        // BR_WAIT means a pop was issued and data lands next cycle
        typedef enum logic {
                BR_IDLE = 1'b0,
                BR_WAIT = 1'b1
        } bridge_state_t;

endpackage : chan_pkg

/* hdl/chan_buf_if.sv */
// Buffer read port and write events between chan_fifo and chan_drain_bridge.
interface chan_buf_if #(
        parameter int DATA_WIDTH = 32
);

        // Pop request from the consumer
        // Acts only while rd_valid is high
        logic                  rd_req;

        // Buffer holds at least one beat
        logic                  rd_valid;

        // Beat data, valid one cycle after the pop
        // Behaves like an SRAM read port
        logic [DATA_WIDTH-1:0] rd_data;

        // One pulse per accepted write into the buffer
        // Feeds the consumer's availability count
        logic                  wr_fire;

        // Buffer drives status, data and write events
        modport buf_side (
                input  rd_req,
                output rd_valid,
                output rd_data,
                output wr_fire
        );

        // Consumer issues pops and watches the rest
        modport cons_side (
                output rd_req,
                input  rd_valid,
                input  rd_data,
                input  wr_fire
        );

endinterface : chan_buf_if

/* hdl/chan_alloc_tracker.sv */
// Producer-side space tracker; reserves burst room and releases it as beats leave the unit.
module chan_alloc_tracker #(
        parameter int DEPTH = 16,
        parameter int CW    = $clog2(DEPTH) + 1
) (
        input  logic            clk,
        input  logic            rst_n,

        // Reservation strobe from the upstream engine
        input  logic            alloc_req,
        input  chan_pkg::size_t alloc_size,

        // Output stream of the unit, watched for releases
        input  logic            out_valid,
        input  logic            out_ready,

        // Registered free space toward the requester
        output logic [CW-1:0]   space_free
);

        // ============================================================
        // Reservation balance
        // ============================================================

        // Beats reserved but not yet gone out of the unit
        logic [CW-1:0] balance;
        logic [CW-1:0] balance_next;

        // A beat leaves on the output handshake
        logic          out_xfer;

        assign out_xfer = out_valid && out_ready;

        // Rise by the burst size, fall by one per departing beat
        // Both may happen in one cycle
        always_comb begin
                balance_next = balance;
                if (alloc_req) begin
                        balance_next = balance_next + CW'(alloc_size);
                end
                if (out_xfer) begin
                        balance_next = balance_next - CW'(1);
                end
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        balance <= '0;
                end else begin
                        balance <= balance_next;
                end
        end

        // ============================================================
        // Space report
        // ============================================================

        // Extra register stage keeps the requester path short
        // Shows the balance one cycle after it changes
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        space_free <= CW'(DEPTH);
                end else begin
                        space_free <= CW'(DEPTH) - balance;
                end
        end

endmodule : chan_alloc_tracker

/* hdl/chan_fifo.sv */
// Circular beat buffer with SRAM-like registered read, serving the drain bridge.
module chan_fifo #(
        parameter int DATA_WIDTH = 32,
        parameter int DEPTH      = 16
) (
        input  logic                  clk,
        input  logic                  rst_n,

        // Input stream from the upstream engine
        input  logic                  in_valid,
        output logic                  in_ready,
        input  logic [DATA_WIDTH-1:0] in_data,

        // Read port and write events toward the consumer
        chan_buf_if.buf_side          bus
);

        // Pointer width, at least one bit
        localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

        // ============================================================
        // Storage and pointers
        // ============================================================

        logic [DATA_WIDTH-1:0] mem [DEPTH];

        logic [AW-1:0]         wr_ptr;
        logic [AW-1:0]         rd_ptr;

        // Beats held, 0 to DEPTH
        logic [AW:0]           count;

        logic                  full;
        logic                  wr_en;
        logic                  rd_en;

        // Advance with explicit wrap so DEPTH need not be a power of two
        function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
                if (ptr == AW'(DEPTH - 1)) begin
                        return '0;
                end
                return ptr + AW'(1);
        endfunction

        // ============================================================
        // Handshake decode
        // ============================================================

        assign full     = (count == (AW + 1)'(DEPTH));
        assign in_ready = !full;
        assign wr_en    = in_valid && in_ready;

        // Pop only when a beat is present
        assign bus.rd_valid = (count != '0);
        assign rd_en        = bus.rd_req && bus.rd_valid;

        // Write event for the consumer's counter
        assign bus.wr_fire = wr_en;

        // ============================================================
        // Control state
        // ============================================================

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        wr_ptr <= '0;
                        rd_ptr <= '0;
                        count  <= '0;
                end else begin
                        if (wr_en) begin
                                wr_ptr <= ptr_inc(wr_ptr);
                        end
                        if (rd_en) begin
                                rd_ptr <= ptr_inc(rd_ptr);
                        end
                        // Simultaneous push and pop leave the count alone
                        case ({wr_en, rd_en})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;
                        endcase
                end
        end

        // ============================================================
        // Data path
        // ============================================================

        always_ff @(posedge clk) begin
                if (wr_en) begin
                        mem[wr_ptr] <= in_data;
                end
        end

        // Registered read, data shows one cycle after the pop
        // Pop needs count > 0, so the slot is never the one being written
        always_ff @(posedge clk) begin
                if (rd_en) begin
                        bus.rd_data <= mem[rd_ptr];
                end
        end

endmodule : chan_fifo

/* hdl/chan_drain_bridge.sv */
// Consumer side; hides buffer read latency with a skid and tracks beats open for draining.
module chan_drain_bridge #(
        parameter int DATA_WIDTH = 32,
        parameter int CW         = 5
) (
        input  logic                  clk,
        input  logic                  rst_n,

        // Drain reservation from the downstream engine
        input  logic                  drain_req,
        input  chan_pkg::size_t       drain_size,

        // Buffer read port
        chan_buf_if.cons_side         bus,

        // Output stream
        output logic                  out_valid,
        input  logic                  out_ready,
        output logic [DATA_WIDTH-1:0] out_data,

        // Status
        output logic [CW-1:0]         data_avail,
        output logic [2:0]            occupancy
);

        // Skid pointer width
        localparam int SW = $clog2(chan_pkg::SKID_DEPTH);

        // ============================================================
        // Read-return tracking
        // ============================================================

        chan_pkg::bridge_state_t state;
        chan_pkg::bridge_state_t state_next;

        logic                  pending;
        logic                  room;
        logic                  pop;
        logic                  push;
        logic                  take;

        logic [DATA_WIDTH-1:0] skid_mem [chan_pkg::SKID_DEPTH];
        logic [SW-1:0]         skid_wptr;
        logic [SW-1:0]         skid_rptr;
        logic [SW:0]           skid_cnt;

        logic [CW-1:0]         avail_cnt;

        // A read is in flight while waiting on returned data
        assign pending = (state == chan_pkg::BR_WAIT);

        // Free slot after counting the beat already in flight
        // Conservative; a same-cycle take is not credited
        assign room = ((skid_cnt + {{SW{1'b0}}, pending}) < 3'(chan_pkg::SKID_DEPTH));

        assign bus.rd_req = room && bus.rd_valid;
        assign pop        = bus.rd_req;

        // Back-to-back pops keep the machine in BR_WAIT
        always_comb begin
                state_next = state;
                case (state)
                        chan_pkg::BR_IDLE: if (pop) state_next = chan_pkg::BR_WAIT;
                        chan_pkg::BR_WAIT: if (!pop) state_next = chan_pkg::BR_IDLE;
                        default:           state_next = chan_pkg::BR_IDLE;
                endcase
        end

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        state <= chan_pkg::BR_IDLE;
                end else begin
                        state <= state_next;
                end
        end

        // ============================================================
        // Skid buffer
        // ============================================================

        // Returned beat lands the cycle after its pop
        assign push = pending;
        assign take = out_valid && out_ready;

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        skid_wptr <= '0;
                        skid_rptr <= '0;
                        skid_cnt  <= '0;
                end else begin
                        if (push) begin
                                skid_wptr <= skid_wptr + 1'b1;
                        end
                        if (take) begin
                                skid_rptr <= skid_rptr + 1'b1;
                        end
                        case ({push, take})
                                2'b10:   skid_cnt <= skid_cnt + 1'b1;
                                2'b01:   skid_cnt <= skid_cnt - 1'b1;
                                default: skid_cnt <= skid_cnt;
                        endcase
                end
        end

        // Slot stays untouched until its beat is taken
        always_ff @(posedge clk) begin
                if (push) begin
                        skid_mem[skid_wptr] <= bus.rd_data;
                end
        end

        assign out_valid = (skid_cnt != '0);
        assign out_data  = skid_mem[skid_rptr];

        // Skid entries plus the beat in flight
        assign occupancy = 3'(skid_cnt) + {2'b00, pending};

        // ============================================================
        // Drain reservation counter
        // ============================================================

        // Written beats in, reserved beats out
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        avail_cnt <= '0;
                end else begin
                        avail_cnt <= avail_cnt + CW'(bus.wr_fire)
                                     - (drain_req ? CW'(drain_size) : CW'(0));
                end
        end

        assign data_avail = avail_cnt;

endmodule : chan_drain_bridge

/* hdl/chan_unit.sv */
// Top level of one buffer channel; sets the sizes and joins tracker, buffer and bridge.
module chan_unit #(
        parameter int DATA_WIDTH = 32,
        parameter int DEPTH      = 16,
        parameter int CW         = $clog2(DEPTH) + 1
) (
        input  logic                  clk,
        input  logic                  rst_n,

        // Space reservation, upstream engine
        input  logic                  alloc_req,
        input  chan_pkg::size_t       alloc_size,
        output logic [CW-1:0]         space_free,

        // Input stream
        input  logic                  in_valid,
        output logic                  in_ready,
        input  logic [DATA_WIDTH-1:0] in_data,

        // Drain reservation, downstream engine
        input  logic                  drain_req,
        input  chan_pkg::size_t       drain_size,
        output logic [CW-1:0]         data_avail,

        // Output stream
        output logic                  out_valid,
        input  logic                  out_ready,
        output logic [DATA_WIDTH-1:0] out_data,

        // Beats held in the bridge
        output logic [2:0]            bridge_occupancy
);

        // Buffer to bridge link
        chan_buf_if #(.DATA_WIDTH(DATA_WIDTH)) buf_bus ();

        // ============================================================
        // Space tracking, released on the output handshake
        // ============================================================
        chan_alloc_tracker #(
                .DEPTH (DEPTH),
                .CW    (CW)
        ) u_alloc_tracker (
                .clk        (clk),
                .rst_n      (rst_n),
                .alloc_req  (alloc_req),
                .alloc_size (alloc_size),
                .out_valid  (out_valid),
                .out_ready  (out_ready),
                .space_free (space_free)
        );

        // ============================================================
        // Beat storage
        // ============================================================
        chan_fifo #(
                .DATA_WIDTH (DATA_WIDTH),
                .DEPTH      (DEPTH)
        ) u_fifo (
                .clk      (clk),
                .rst_n    (rst_n),
                .in_valid (in_valid),
                .in_ready (in_ready),
                .in_data  (in_data),
                .bus      (buf_bus.buf_side)
        );

        // Skid bridge and drain count
        chan_drain_bridge #(
                .DATA_WIDTH (DATA_WIDTH),
                .CW         (CW)
        ) u_drain_bridge (
                .clk        (clk),
                .rst_n      (rst_n),
                .drain_req  (drain_req),
                .drain_size (drain_size),
                .bus        (buf_bus.cons_side),
                .out_valid  (out_valid),
                .out_ready  (out_ready),
                .out_data   (out_data),
                .data_avail (data_avail),
                .occupancy  (bridge_occupancy)
        );

endmodule : chan_unit

/* sim/chan_unit_checker.sv */
// Handshake and bound assertions for chan_unit, attached to every instance by the bind below.
module chan_unit_checker #(
        parameter int DATA_WIDTH = 32
) (
        input logic                  clk,
        input logic                  rst_n,
        input logic                  out_valid,
        input logic                  out_ready,
        input logic [DATA_WIDTH-1:0] out_data,
        input logic [2:0]            bridge_occupancy,
        input logic                  in_valid,
        input logic                  in_ready,
        // Buffer holds a beat
        input logic                  buf_valid,
        // Pop request toward the buffer
        input logic                  buf_req
);

        // Beats in the buffer, counted from accepted writes and pops
        int held;

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        held <= 0;
                end else begin
                        held <= held + int'(in_valid && in_ready) - int'(buf_req && buf_valid);
                end
        end

        // Offered beat holds until taken
        a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
                out_valid && !out_ready |=> out_valid && $stable(out_data))
                else $error("out_valid or out_data changed before the beat was taken");

        // Skid plus the read in flight
        a_occupancy: assert property (@(posedge clk) disable iff (!rst_n)
                bridge_occupancy <= 3'(chan_pkg::SKID_DEPTH))
                else $error("bridge occupancy exceeds the skid depth");

        // Only a full buffer drops in_ready
        a_ready_empty: assert property (@(posedge clk) disable iff (!rst_n)
                held == 0 |-> in_ready)
                else $error("in_ready low while the buffer is empty");

endmodule : chan_unit_checker

bind chan_unit chan_unit_checker #(.DATA_WIDTH(DATA_WIDTH)) u_checker (
        .clk              (clk),
        .rst_n            (rst_n),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .out_data         (out_data),
        .bridge_occupancy (bridge_occupancy),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .buf_valid        (buf_bus.rd_valid),
        .buf_req          (buf_bus.rd_req)
);

/* sim/tb_chan_unit.sv */
// Testbench for chan_unit; runs sim/chan_tests.txt and checks beats against a queue model.
module tb_chan_unit;

        localparam int DATA_WIDTH = 32;
        localparam int DEPTH      = 16;
        localparam int CW         = $clog2(DEPTH) + 1;
        // Cycles allowed for any single wait
        localparam int TIMEOUT    = 200;

        logic                  clk;
        logic                  rst_n;
        logic                  alloc_req;
        chan_pkg::size_t       alloc_size;
        logic [CW-1:0]         space_free;
        logic                  in_valid;
        logic                  in_ready;
        logic [DATA_WIDTH-1:0] in_data;
        logic                  drain_req;
        chan_pkg::size_t       drain_size;
        logic [CW-1:0]         data_avail;
        logic                  out_valid;
        logic                  out_ready;
        logic [DATA_WIDTH-1:0] out_data;
        logic [2:0]            bridge_occupancy;

        // Beats accepted at the input and not yet seen at the output
        logic [DATA_WIDTH-1:0] model_q[$];
        logic [31:0]           lcg_state;
        // out_ready mode, 0 low, 1 high, 2 random
        int                    ready_mode;
        // Output beats seen but not yet claimed by a read command
        int                    unclaimed;

        chan_unit #(
                .DATA_WIDTH (DATA_WIDTH),
                .DEPTH      (DEPTH)
        ) u_chan_unit (
                .clk              (clk),
                .rst_n            (rst_n),
                .alloc_req        (alloc_req),
                .alloc_size       (alloc_size),
                .space_free       (space_free),
                .in_valid         (in_valid),
                .in_ready         (in_ready),
                .in_data          (in_data),
                .drain_req        (drain_req),
                .drain_size       (drain_size),
                .data_avail       (data_avail),
                .out_valid        (out_valid),
                .out_ready        (out_ready),
                .out_data         (out_data),
                .bridge_occupancy (bridge_occupancy)
        );

        initial begin
                clk = 1'b0;
                forever begin
                        #5 clk = ~clk;
                end
        end

        // ============================================================
        // Helpers
        // ============================================================

        // Numerical Recipes constants
        function automatic logic [31:0] lcg_next(input logic [31:0] state);
                return state * 32'd1664525 + 32'd1013904223;
        endfunction

        task automatic fail_run(input string reason);
                $display("%s", reason);
                $display("tests failed");
                $fatal(1, "run stopped");
        endtask

        task automatic check_value(input string what, input logic [31:0] got,
                                   input logic [31:0] expected);
                if (got !== expected) begin
                        $display("error at %0t: %s is %h, expected %h", $time, what, got, expected);
                        $display("tests failed");
                        $fatal(1, "value mismatch");
                end
        endtask

        // One clock, entered and left on a falling edge
        // A beat seen here leaves on the coming rising edge
        task automatic step();
                if (ready_mode == 2) begin
                        lcg_state = lcg_next(lcg_state);
                        out_ready = lcg_state[16];
                end else begin
                        out_ready = (ready_mode == 1);
                end
                if (out_valid && out_ready) begin
                        if (model_q.size() == 0) begin
                                fail_run("an output beat appeared with no beat written");
                        end else begin
                                check_value("out_data", out_data, model_q.pop_front());
                                unclaimed++;
                        end
                end
                @(posedge clk);
                @(negedge clk);
        endtask

        // Hold the beat until in_ready takes it
        task automatic write_beat(input logic [DATA_WIDTH-1:0] value);
                int waited;
                waited   = 0;
                in_valid = 1'b1;
                in_data  = value;
                while (!in_ready) begin
                        if (waited == TIMEOUT) begin
                                fail_run("in_ready stayed low and a write was never accepted");
                        end else begin
                                step();
                                waited++;
                        end
                end
                model_q.push_back(value);
                step();
                in_valid = 1'b0;
        endtask

        task automatic alloc_burst(input chan_pkg::size_t size);
                alloc_req  = 1'b1;
                alloc_size = size;
                step();
                alloc_req  = 1'b0;
        endtask

        task automatic drain_burst(input chan_pkg::size_t size);
                drain_req  = 1'b1;
                drain_size = size;
                step();
                drain_req  = 1'b0;
        endtask

        // Wait until enough output beats have been checked
        task automatic read_beats(input int count);
                int waited;
                waited = 0;
                while (unclaimed < count) begin
                        if (waited == TIMEOUT) begin
                                fail_run("output beats did not arrive in time");
                        end else begin
                                step();
                                waited++;
                        end
                end
                unclaimed -= count;
        endtask

        task automatic run_command(input logic [7:0] op, input logic [31:0] arg);
                case (op)
                        "W": write_beat(arg);
                        // Burst of LCG data
                        "P": begin
                                for (int i = 0; i < int'(arg); i++) begin
                                        lcg_state = lcg_next(lcg_state);
                                        write_beat(lcg_state);
                                end
                        end
                        "A": alloc_burst(arg[7:0]);
                        "D": drain_burst(arg[7:0]);
                        "R": read_beats(int'(arg));
                        // Idle so the two-stage space report settles
                        "S": begin
                                repeat (3) step();
                                check_value("space_free", 32'(space_free), arg);
                        end
                        "V": check_value("data_avail", 32'(data_avail), arg);
                        "F": begin
                                check_value("in_ready", 32'(in_ready), arg);
                                // Stalled output with a full buffer leaves the skid full
                                if (arg == 32'd0 && ready_mode == 0) begin
                                        check_value("bridge_occupancy", 32'(bridge_occupancy),
                                                    32'(chan_pkg::SKID_DEPTH));
                                end
                        end
                        "M": ready_mode = int'(arg);
                        default: fail_run("the test file holds an unknown command");
                endcase
        endtask

        // ============================================================
        // Main sequence
        // ============================================================

        initial begin
                int          fd;
                int          n;
                string       line;
                logic [7:0]  op;
                logic [31:0] arg;
                rst_n      = 1'b0;
                alloc_req  = 1'b0;
                alloc_size = '0;
                in_valid   = 1'b0;
                in_data    = '0;
                drain_req  = 1'b0;
                drain_size = '0;
                out_ready  = 1'b0;
                ready_mode = 0;
                unclaimed  = 0;
                lcg_state  = 32'h4968;
                repeat (3) @(posedge clk);
                @(negedge clk);
                rst_n = 1'b1;
                check_value("out_valid", 32'(out_valid), 32'd0);
                // Skid empty and no read in flight
                check_value("bridge_occupancy", 32'(bridge_occupancy), 32'd0);

                fd = $fopen("sim/chan_tests.txt", "r");
                if (fd == 0) begin
                        fail_run("could not open sim/chan_tests.txt");
                end else begin
                        // Comment and blank lines scan fewer than two fields
                        while ($fgets(line, fd) != 0) begin
                                n = $sscanf(line, "%c %h", op, arg);
                                if (n == 2 && op != "#") begin
                                        run_command(op, arg);
                                end
                        end
                        $fclose(fd);
                        $display("all tests passed");
                        $finish;
                end
        end

endmodule : tb_chan_unit

/* sim/chan_tests.txt */
# <op> <hex arg>: W write beat, P write arg beats of LCG data, A alloc, D drain, R read beats
# S expect space_free, V expect data_avail, F expect in_ready, M out_ready 0 low 1 high 2 random
S 10
V 00
F 1
M 1
A 04
W 11111111
W 22222222
W 33333333
W 44444444
V 04
R 4
S 10
D 04
V 00
A 08
S 08
M 0
P 8
V 08
D 03
V 05
M 2
R 5
M 0
S 0d
D 05
V 00
M 2
R 3
S 10
M 0
A 10
P 14
F 0
V 14
A 04
M 2
R 14
F 1
D 14
V 00
S 10

/* sim.f */
hdl/chan_pkg.sv
hdl/chan_buf_if.sv
hdl/chan_alloc_tracker.sv
hdl/chan_fifo.sv
hdl/chan_drain_bridge.sv
hdl/chan_unit.sv
sim/chan_unit_checker.sv
sim/tb_chan_unit.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -Wno-fatal --top-module tb_chan_unit -f sim.f || exit 1
out=$(./obj_dir/Vtb_chan_unit 2>&1)
echo "$out"
echo "$out" | grep -qx "all tests passed" && echo "PASS" || { echo "FAIL"; exit 1; }
